// File: tb/tdc_trace.txt
# name len meas_cnt first_ofs spacing fast ready_mode exp_t0 exp_t1 exp_t2 exp_t12v
# ready_mode 0 = ready high, 1 = random gaps, 2 = held low so this window's record drops
period_single   40 1 7  0  0 0 40 7  7  1
period_edge0    32 1 0  0  0 0 32 0  0  1
multi_edges     50 4 5  9  0 0 50 5  32 1
no_edge         36 0 0  0  0 0 36 0  0  0
fast_div        60 7 4  6  1 0 60 4  28 1
fast_cont       48 3 6  5  1 0 48 11 11 1
normal_again    40 2 10 20 0 0 40 10 30 1
fast_again      44 5 3  4  1 0 44 3  19 1
gaps_a          60 2 12 25 0 1 60 12 37 1
gaps_b          64 3 9  17 0 1 64 9  43 1
gaps_none       56 0 0  0  0 1 56 0  0  0
overrun_block   20 1 5  0  0 2 20 5  5  1

// File: compile.f
common/tdc_cfg_pkg.sv
common/tdc_rec_pkg.sv
common/tdc_rec_if.sv
hw/tdc_edge_decode.sv
hw/tdc_interval_core.sv
hw/tdc_byte_serializer.sv
hw/tdc_top.sv
tb/tdc_assertions.sv
tb/tdc_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tdc_tb \
    -f compile.f -o tdc_sim \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/tdc_sim > sim.log 2>&1
cat sim.log
grep -q '\*\*\* FAILED \*\*\*' sim.log && { echo "Simulation failed"; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

// File: tb/tdc_tb.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_tb;

    localparam int COUNT_W   = tdc_cfg_pkg::COUNTER_WIDTH;
    localparam int CNT_BYTES = tdc_cfg_pkg::COUNTER_BYTES;
    localparam int REC_BYTES = tdc_cfg_pkg::REC_BYTES;
    localparam logic [COUNT_W-1:0] ALL_ONES = '1;
    localparam string TRACE_FILE = "tb/tdc_trace.txt";

    logic       i_clk_tdc;
    logic       rst_tdc;
    logic       i_gate;
    logic       i_meas;
    logic       i_meas_fast;
    logic       i_m_tready;
    logic [7:0] o_m_tdata;
    logic       o_m_tvalid;
    logic       o_m_tlast;
    logic       o_overrun;

    // One entry per trace line
    string name_q[$];
    int    len_q[$];
    int    cnt_q[$];
    int    first_q[$];
    int    step_q[$];
    int    fast_mode_q[$];
    int    ready_mode_q[$];
    int    t0_q[$];
    int    t1_q[$];
    int    t2_q[$];
    int    t12v_q[$];

    // Lines whose record should reach the output, in order
    int          exp_idx_q[$];
    int          exp_total   = 0;
    bit          overrun_exp = 1'b0;
    int          rec_count   = 0;
    int          byte_pos    = 0;
    logic [7:0]  byte_buf [REC_BYTES];
    logic [31:0] rnd_state   = 32'd44;
    bit          trace_loaded = 1'b0;
    int          cycle_limit = 0;
    int          cycle_cnt   = 0;

    tdc_top tdc_top_i (
        .i_clk_tdc  (i_clk_tdc),
        .rst_tdc    (rst_tdc),
        .i_gate     (i_gate),
        .i_meas     (i_meas),
        .i_meas_fast(i_meas_fast),
        .o_m_tdata  (o_m_tdata),
        .o_m_tvalid (o_m_tvalid),
        .o_m_tlast  (o_m_tlast),
        .i_m_tready (i_m_tready),
        .o_overrun  (o_overrun)
    );

    // ====================
    // Helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp_v, act_v);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // Measured edges at first, first+step, ... for cnt edges
    function automatic bit is_meas_edge(input int idx, input int c);
        int rel;
        rel = c - first_q[idx];
        if (cnt_q[idx] == 0 || rel < 0) return 1'b0;
        if (step_q[idx] == 0) return rel == 0;
        return (rel % step_q[idx] == 0) && (rel / step_q[idx] < cnt_q[idx]);
    endfunction

    // Counter bytes arrive low byte first
    function automatic logic [COUNT_W-1:0] rebuild_count(input int base);
        logic [COUNT_W-1:0] v;
        v = '0;
        for (int k = CNT_BYTES - 1; k >= 0; k--) begin
            v = (v << 8) | COUNT_W'(byte_buf[base + k]);
        end
        return v;
    endfunction

    task automatic load_trace();
        int    fd;
        int    rc;
        int    total;
        string line;
        string nm;
        int    v[10];
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the trace file %s", TRACE_FILE);
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            total = 0;
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 2 && line.substr(0, 0) != "#") begin
                    rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d", nm, v[0], v[1],
                                 v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (rc == 11) begin
                        name_q.push_back(nm);
                        len_q.push_back(v[0]);
                        cnt_q.push_back(v[1]);
                        first_q.push_back(v[2]);
                        step_q.push_back(v[3]);
                        fast_mode_q.push_back(v[4]);
                        ready_mode_q.push_back(v[5]);
                        t0_q.push_back(v[6]);
                        t1_q.push_back(v[7]);
                        t2_q.push_back(v[8]);
                        t12v_q.push_back(v[9]);
                        total += v[0];
                        // Blocked window drops its own record
                        if (v[5] == 2) begin
                            overrun_exp = 1'b1;
                        end else begin
                            exp_idx_q.push_back(name_q.size() - 1);
                        end
                    end
                end
            end
            $fclose(fd);
            exp_total    = exp_idx_q.size();
            cycle_limit  = total + 200;
            trace_loaded = 1'b1;
        end
    endtask

    task automatic drive_window(input int idx);
        for (int c = 0; c < len_q[idx]; c++) begin
            @(posedge i_clk_tdc);
            i_gate      <= (c == 0);
            i_meas      <= is_meas_edge(idx, c);
            i_meas_fast <= (fast_mode_q[idx] != 0);
            case (ready_mode_q[idx])
                0: i_m_tready <= 1'b1;
                1: begin
                    rnd_state   = xorshift32(rnd_state);
                    i_m_tready <= (rnd_state[1:0] != 2'b00);
                end
                default: i_m_tready <= 1'b0;
            endcase
        end
    endtask

    task automatic check_record(input int idx);
        logic [COUNT_W-1:0] t1_exp;
        logic [COUNT_W-1:0] t2_exp;
        // No measured edge in the window, t1 and t2 read as all ones
        t1_exp = (t12v_q[idx] != 0) ? COUNT_W'(t1_q[idx]) : ALL_ONES;
        t2_exp = (t12v_q[idx] != 0) ? COUNT_W'(t2_q[idx]) : ALL_ONES;
        check_value({name_q[idx], " t0"}, t0_q[idx], 32'(rebuild_count(0)));
        check_value({name_q[idx], " t1"}, 32'(t1_exp), 32'(rebuild_count(CNT_BYTES)));
        check_value({name_q[idx], " t2"}, 32'(t2_exp), 32'(rebuild_count(2 * CNT_BYTES)));
    endtask

    task automatic collect_byte();
        int idx;
        if (exp_idx_q.size() == 0) begin
            $display("Output byte seen after every expected record was received");
            $display("*** FAILED ***");
            $fatal(1);
        end else begin
            idx = exp_idx_q[0];
            byte_buf[byte_pos] = o_m_tdata;
            check_value({name_q[idx], " tlast"}, 32'(byte_pos == REC_BYTES - 1),
                        32'(o_m_tlast));
            if (byte_pos == REC_BYTES - 1) begin
                check_record(idx);
                void'(exp_idx_q.pop_front());
                byte_pos = 0;
                rec_count++;
            end else begin
                byte_pos++;
            end
        end
    endtask

    // ====================
    // Clock, collector, timeout
    // ====================

    initial begin
        i_clk_tdc = 1'b0;
        forever #4 i_clk_tdc = ~i_clk_tdc;
    end

    // Outputs and ready only move on the rising edge
    always @(negedge i_clk_tdc) begin
        if (!rst_tdc && o_m_tvalid && i_m_tready) begin
            collect_byte();
        end
    end

    initial begin
        wait (trace_loaded);
        while (cycle_cnt < cycle_limit) begin
            @(posedge i_clk_tdc);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $fatal(1);
    end

    // ====================
    // Main sequence
    // ====================

    initial begin
        rst_tdc     = 1'b1;
        i_gate      = 1'b0;
        i_meas      = 1'b0;
        i_meas_fast = 1'b0;
        i_m_tready  = 1'b1;
        load_trace();
        repeat (2) @(posedge i_clk_tdc);
        rst_tdc <= 1'b0;
        repeat (3) @(posedge i_clk_tdc);
        for (int i = 0; i < name_q.size(); i++) begin
            if (ready_mode_q[i] == 2) begin
                @(negedge i_clk_tdc);
                check_value({name_q[i], " overrun before block"}, 0, 32'(o_overrun));
            end
            drive_window(i);
        end
        // Closing gate edge ends the last window
        @(posedge i_clk_tdc);
        i_gate <= 1'b1;
        i_meas <= 1'b0;
        @(posedge i_clk_tdc);
        i_gate <= 1'b0;
        // Stream stays blocked while the last record arrives
        repeat (12) @(posedge i_clk_tdc);
        i_m_tready <= 1'b1;
        while (rec_count < exp_total) @(posedge i_clk_tdc);
        @(negedge i_clk_tdc);
        check_value("final overrun", 32'(overrun_exp), 32'(o_overrun));
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tdc_assertions.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_assertions (
    input wire       i_clk_tdc,
    input wire       rst_tdc,
    input wire       i_valid,
    input wire       i_ready,
    input wire [7:0] i_data,
    input wire       i_last,
    input wire       i_s0,
    input wire       i_s1
);

    // Stalled byte holds until the consumer takes it
    stream_hold: assert property (@(posedge i_clk_tdc) disable iff (rst_tdc)
        (i_valid && !i_ready) |=> ($stable(i_data) && $stable(i_last)))
        else $error("output byte or last changed while stalled");

    last_needs_valid: assert property (@(posedge i_clk_tdc) disable iff (rst_tdc)
        i_last |-> i_valid)
        else $error("last high without valid");

    // Edge pulses are single cycle
    s0_single: assert property (@(posedge i_clk_tdc) disable iff (rst_tdc)
        i_s0 |=> !i_s0)
        else $error("gate edge pulse longer than one cycle");

    s1_single: assert property (@(posedge i_clk_tdc) disable iff (rst_tdc)
        i_s1 |=> !i_s1)
        else $error("measured edge pulse longer than one cycle");

endmodule

bind tdc_byte_serializer tdc_assertions stream_checks (
    .i_clk_tdc(i_clk_tdc),
    .rst_tdc  (rst_tdc),
    .i_valid  (o_m_tvalid),
    .i_ready  (i_m_tready),
    .i_data   (o_m_tdata),
    .i_last   (o_m_tlast),
    .i_s0     (1'b0),
    .i_s1     (1'b0)
);

bind tdc_edge_decode tdc_assertions pulse_checks (
    .i_clk_tdc(i_clk_tdc),
    .rst_tdc  (rst_tdc),
    .i_valid  (1'b0),
    .i_ready  (1'b0),
    .i_data   (8'h00),
    .i_last   (1'b0),
    .i_s0     (o_s0_pulse),
    .i_s1     (o_s1_pulse)
);

`default_nettype wire

// File: hw/tdc_top.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_top #(
    parameter int FF_SYNC_DEPTH = 2,
    parameter int DIV_MEAS_FAST = 4
) (
    input  wire        i_clk_tdc,
    input  wire        rst_tdc,
    // Asynchronous inputs
    input  wire        i_gate,
    input  wire        i_meas,
    input  wire        i_meas_fast,
    // Byte stream out
    output logic [7:0] o_m_tdata,
    output logic       o_m_tvalid,
    output logic       o_m_tlast,
    input  wire        i_m_tready,
    output logic       o_overrun
);

    // Edge pulses into the core
    logic s0_pulse;
    logic s1_pulse;

    // Finished window records
    tdc_rec_if rec_if ();

    tdc_edge_decode #(
        .FF_SYNC_DEPTH(FF_SYNC_DEPTH),
        .DIV_MEAS_FAST(DIV_MEAS_FAST)
    ) u_edge_decode (
        .i_clk_tdc  (i_clk_tdc),
        .rst_tdc    (rst_tdc),
        .i_gate     (i_gate),
        .i_meas     (i_meas),
        .i_meas_fast(i_meas_fast),
        .o_s0_pulse (s0_pulse),
        .o_s1_pulse (s1_pulse)
    );

    tdc_interval_core u_interval_core (
        .i_clk_tdc (i_clk_tdc),
        .rst_tdc   (rst_tdc),
        .i_s0_pulse(s0_pulse),
        .i_s1_pulse(s1_pulse),
        .rec       (rec_if.producer)
    );

    tdc_byte_serializer u_byte_serializer (
        .i_clk_tdc (i_clk_tdc),
        .rst_tdc   (rst_tdc),
        .rec       (rec_if.consumer),
        .o_m_tdata (o_m_tdata),
        .o_m_tvalid(o_m_tvalid),
        .o_m_tlast (o_m_tlast),
        .i_m_tready(i_m_tready),
        .o_overrun (o_overrun)
    );

endmodule

`default_nettype wire

// File: hw/tdc_byte_serializer.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_byte_serializer (
    input  wire         i_clk_tdc,
    input  wire         rst_tdc,
    tdc_rec_if.consumer rec,
    output logic [7:0]  o_m_tdata,
    output logic        o_m_tvalid,
    output logic        o_m_tlast,
    input  wire         i_m_tready,
    output logic        o_overrun
);

    localparam int IDX_W = $clog2(tdc_cfg_pkg::REC_BYTES);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(tdc_cfg_pkg::REC_BYTES - 1);

    // ====================
    // Holding register
    // ====================

    tdc_rec_pkg::rec_word_u word_q;
    logic [IDX_W-1:0]       byte_idx_q;
    logic                   busy_q;
    logic                   accept;
    logic                   xfer;

    // A new record is taken only when the previous one is fully out
    assign accept = rec.rec_valid && !busy_q;
    assign xfer   = busy_q && i_m_tready;

    always_ff @(posedge i_clk_tdc) begin
        if (accept) begin
            word_q.f.t0 <= rec.rec_t0;
            // Invalid t1/t2 are sent as all ones
            word_q.f.t1 <= rec.rec_t12_valid ? rec.rec_t1 : tdc_rec_pkg::COUNT_MAX;
            word_q.f.t2 <= rec.rec_t12_valid ? rec.rec_t2 : tdc_rec_pkg::COUNT_MAX;
        end
    end

    // ====================
    // Byte walk
    // ====================

    always_ff @(posedge i_clk_tdc or posedge rst_tdc) begin
        if (rst_tdc) begin
            busy_q     <= 1'b0;
            byte_idx_q <= '0;
            o_overrun  <= 1'b0;
        end else begin
            if (accept) begin
                busy_q     <= 1'b1;
                byte_idx_q <= '0;
            end else if (xfer) begin
                if (byte_idx_q == IDX_LAST) begin
                    busy_q <= 1'b0;
                end else begin
                    byte_idx_q <= byte_idx_q + 1'b1;
                end
            end

            // Sticky, a dropped record is never recovered
            if (rec.rec_valid && busy_q) begin
                o_overrun <= 1'b1;
            end
        end
    end

    // Lowest byte first, held steady while ready is low
    assign o_m_tdata  = word_q.b[byte_idx_q];
    assign o_m_tvalid = busy_q;
    assign o_m_tlast  = busy_q && (byte_idx_q == IDX_LAST);

endmodule

`default_nettype wire

// File: hw/tdc_interval_core.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_interval_core (
    input  wire         i_clk_tdc,
    input  wire         rst_tdc,
    input  wire         i_s0_pulse,
    input  wire         i_s1_pulse,
    tdc_rec_if.producer rec
);

    // First count value of a fresh window
    localparam tdc_rec_pkg::count_t COUNT_ONE = 1;

    // ====================
    // Window state
    // ====================

    // Set by the first gate edge, the window before it is unknown
    logic                started_q;

    // Cycles since the window's opening gate edge
    tdc_rec_pkg::count_t win_cnt_q;

    // At least one measured edge in the current window
    logic                seen_q;

    // Offsets of the first and latest measured edge
    tdc_rec_pkg::count_t first_ofs_q;
    tdc_rec_pkg::count_t last_ofs_q;

    logic s1_in_window;

    // Measured edges on a gate edge go to the new window instead
    assign s1_in_window = started_q && i_s1_pulse && !i_s0_pulse;

    always_ff @(posedge i_clk_tdc or posedge rst_tdc) begin
        if (rst_tdc) begin
            started_q     <= 1'b0;
            win_cnt_q     <= '0;
            seen_q        <= 1'b0;
            rec.rec_valid <= 1'b0;
        end else begin
            // Nothing to report on the very first gate edge
            rec.rec_valid <= i_s0_pulse && started_q;

            if (i_s0_pulse) begin
                started_q <= 1'b1;
                win_cnt_q <= COUNT_ONE;
                seen_q    <= i_s1_pulse;
            end else if (started_q) begin
                // Saturate rather than wrap on a missing gate
                if (win_cnt_q != tdc_rec_pkg::COUNT_MAX) begin
                    win_cnt_q <= win_cnt_q + 1'b1;
                end
                if (i_s1_pulse) begin
                    seen_q <= 1'b1;
                end
            end
        end
    end

    // ====================
    // Offsets and record
    // ====================

    always_ff @(posedge i_clk_tdc) begin
        if (i_s0_pulse) begin
            // Hand the finished window over
            rec.rec_t0        <= win_cnt_q;
            rec.rec_t1        <= first_ofs_q;
            rec.rec_t2        <= last_ofs_q;
            rec.rec_t12_valid <= seen_q;

            // Offset 0 if a measured edge coincides with the gate edge
            first_ofs_q <= '0;
            last_ofs_q  <= '0;
        end else if (s1_in_window) begin
            if (!seen_q) begin
                first_ofs_q <= win_cnt_q;
            end
            last_ofs_q <= win_cnt_q;
        end
    end

endmodule

`default_nettype wire

// File: hw/tdc_edge_decode.sv
`default_nettype none
`timescale 1ns/10ps

module tdc_edge_decode #(
    parameter int FF_SYNC_DEPTH = 2,
    parameter int DIV_MEAS_FAST = 4
) (
    input  wire  i_clk_tdc,
    input  wire  rst_tdc,
    input  wire  i_gate,
    input  wire  i_meas,
    input  wire  i_meas_fast,
    output logic o_s0_pulse,
    output logic o_s1_pulse
);

    // Bit positions inside each synchronizer stage
    localparam int IDX_GATE = 0;
    localparam int IDX_MEAS = 1;
    localparam int IDX_FAST = 2;
    localparam int SYNC_LAST = FF_SYNC_DEPTH - 1;

    // Divider count width, at least one bit
    localparam int DIV_W = (DIV_MEAS_FAST > 1) ? $clog2(DIV_MEAS_FAST) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(DIV_MEAS_FAST - 1);

    // ====================
    // Synchronizers
    // ====================

    // Three chains side by side, stage 0 samples the pins
    logic [FF_SYNC_DEPTH-1:0][2:0] sync_q;
    logic [1:0]                    prev_q;
    logic                          fast_q;
    logic                          gate_edge_q;
    logic                          meas_edge_q;
    logic [DIV_W-1:0]              div_cnt_q;

    logic gate_s;
    logic meas_s;
    logic fast_s;
    logic mode_chg;
    logic meas_sel;

    assign gate_s   = sync_q[SYNC_LAST][IDX_GATE];
    assign meas_s   = sync_q[SYNC_LAST][IDX_MEAS];
    assign fast_s   = sync_q[SYNC_LAST][IDX_FAST];
    assign mode_chg = fast_s ^ fast_q;

    // Undivided edge, or only the edge where the divider sits at zero
    assign meas_sel = fast_q ? (meas_edge_q && (div_cnt_q == '0)) : meas_edge_q;

    always_ff @(posedge i_clk_tdc or posedge rst_tdc) begin
        if (rst_tdc) begin
            sync_q <= '0;
        end else begin
            sync_q[0] <= {i_meas_fast, i_meas, i_gate};
            for (int i = 1; i < FF_SYNC_DEPTH; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    // ====================
    // Edges and divider
    // ====================

    always_ff @(posedge i_clk_tdc or posedge rst_tdc) begin
        if (rst_tdc) begin
            prev_q      <= '0;
            fast_q      <= 1'b0;
            gate_edge_q <= 1'b0;
            meas_edge_q <= 1'b0;
            div_cnt_q   <= '0;
            o_s0_pulse  <= 1'b0;
            o_s1_pulse  <= 1'b0;
        end else begin
            prev_q      <= {meas_s, gate_s};
            fast_q      <= fast_s;
            gate_edge_q <= gate_s & ~prev_q[0];
            meas_edge_q <= meas_s & ~prev_q[1];

            // Second stage keeps gate and measured paths equally delayed
            o_s0_pulse <= gate_edge_q;
            o_s1_pulse <= meas_sel;

            // Count restarts on any change of the mode input
            if (mode_chg) begin
                div_cnt_q <= '0;
            end else if (fast_q && meas_edge_q) begin
                if (div_cnt_q == DIV_LAST) begin
                    div_cnt_q <= '0;
                end else begin
                    div_cnt_q <= div_cnt_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: common/tdc_rec_if.sv
`default_nettype none
`timescale 1ns/10ps

// One finished gate window, strobed for a single cycle
interface tdc_rec_if;

    logic                  rec_valid;
    tdc_rec_pkg::count_t   rec_t0;
    tdc_rec_pkg::count_t   rec_t1;
    tdc_rec_pkg::count_t   rec_t2;
    logic                  rec_t12_valid;

    // Interval core side
    modport producer (
        output rec_valid,
        output rec_t0,
        output rec_t1,
        output rec_t2,
        output rec_t12_valid
    );

    // Serializer side, no ready back to the core
    modport consumer (
        input rec_valid,
        input rec_t0,
        input rec_t1,
        input rec_t2,
        input rec_t12_valid
    );

endinterface

`default_nettype wire

// File: common/tdc_rec_pkg.sv
`default_nettype none

package tdc_rec_pkg;

    // One measurement counter
    typedef logic [tdc_cfg_pkg::COUNTER_WIDTH-1:0] count_t;

    // Saturation value of every counter
    localparam count_t COUNT_MAX = '1;

    // ====================
    // Record layout
    // ====================

    // t0 sits in the lowest word so it leaves the serializer first
    typedef struct packed {
        count_t t2;
        count_t t1;
        count_t t0;
    } rec_fields_t;

    // Byte view of the same 48 bits, byte 0 is t0 low
    typedef logic [tdc_cfg_pkg::REC_BYTES-1:0][7:0] rec_bytes_t;

    // Written through the fields, read out through the bytes
    typedef union packed {
        rec_fields_t f;
        rec_bytes_t  b;
    } rec_word_u;

endpackage

`default_nettype wire

// File: common/tdc_cfg_pkg.sv
`default_nettype none

package tdc_cfg_pkg;

    // ====================
    // Counter sizing
    // ====================

    // Bytes used to carry one counter on the output stream
    localparam int COUNTER_BYTES = 2;

    // Counter width follows the byte count
    localparam int COUNTER_WIDTH = COUNTER_BYTES * 8;

    // ====================
    // Record sizing
    // ====================

    // t0, t1 and t2
    localparam int NUM_COUNTERS = 3;

    // Bytes per serialized record
    localparam int REC_BYTES = NUM_COUNTERS * COUNTER_BYTES;

endpackage

`default_nettype wire
